// ==== dmm_top.f ====
hw/dmm_pkg.sv
hw/reg_bank.sv
hw/adc_mock.sv
hw/sample_acq_az.sv
hw/output_mux.sv
hw/dmm_top.sv
tb/tb_dmm_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_dmm_top -f dmm_top.f \
  && ./obj_dir/Vtb_dmm_top | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

// ==== tb/dmm_testdata.txt ====
// op addr value expected, hex. op 0 write, 1 read, 2 mode check, 3 az run, f end
// read: value drives hw flags. mode check: addr is the mode. az run: value is pulses to disarm
0 04 00ABCDEF 00ABCDEF
1 04 00000000 00ABCDEF
0 05 00000003 00000003
0 06 0000000C 0000000C
0 07 00000002 00000002
0 08 00000014 00000014
1 05 00000000 00000003
1 06 00000000 0000000C
1 07 00000000 00000002
1 08 00000000 00000014
1 3F 00000000 00000000
1 02 0000000A 00000AAA
1 02 00000005 000005AA
0 02 12345678 12345678
1 02 00000000 000000AA
0 01 FFF5A5C3 FFF5A5C3
2 00 00000000 0005A5C3
2 01 00000000 00000000
2 02 00000000 0007FFFF
2 03 00000000 00000000
0 04 0000000A 0000000A
3 05 00000003 00000002
F 00 00000000 00000000

// ==== tb/tb_dmm_top.sv ====
`default_nettype none

module tb_dmm_top
  import dmm_pkg::*;
();

  localparam int COUNT_W     = 16;
  localparam int MAX_OPS     = 64;
  localparam int CMD_TIMEOUT = 50;     // cycles per handshake wait
  localparam int AZ_TIMEOUT  = 2000;
  localparam int QUIET_CYC   = 150;    // longer than one full hi/lo pair

  logic                  CLK;
  logic                  reset_i;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  reg_cmd_t              cmd_i;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  reg_word_t             rsp_data_o;
  logic [HW_FLAGS_W-1:0] hw_flags_i;
  logic [LEDS_W-1:0]     leds_o;
  logic [MONITOR_W-1:0]  monitor_o;
  logic [AZMUX_W-1:0]    azmux_o;
  logic [PC_SW_W-1:0]    pc_sw_o;
  logic                  meas_complete_o;

  reg_word_t          testdata [0:4*MAX_OPS-1];   // four words per op
  int                 value_errors;
  int                 other_errors;
  logic [31:0]        lcg_state;
  logic               watch_pulses;
  pins_t              pulse_q [$];                // pins seen at each meas_complete
  logic [AZMUX_W-1:0] sh_azmux_lo;                // last written sequencer params
  logic [AZMUX_W-1:0] sh_azmux_hi;
  logic [PC_SW_W-1:0] sh_pc_hi;

  dmm_top #(
    .COUNT_W(COUNT_W)
  ) i_dmm_top (
    .CLK            (CLK),
    .reset_i        (reset_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_i          (cmd_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_data_o     (rsp_data_o),
    .hw_flags_i     (hw_flags_i),
    .leds_o         (leds_o),
    .monitor_o      (monitor_o),
    .azmux_o        (azmux_o),
    .pc_sw_o        (pc_sw_o),
    .meas_complete_o(meas_complete_o)
  );

  always #20 CLK = ~CLK;   // period 40

  ////////////////////////////////////////////////////////////
  // helpers

  function automatic pins_t pins_now();
    pins_t p;
    p.meas_complete = meas_complete_o;
    p.azmux         = azmux_o;
    p.pc_sw         = pc_sw_o;
    p.monitor       = monitor_o;
    p.leds          = leds_o;
    return p;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // every wait goes through here, so no pulse is missed
  task automatic step_clk();
    @(negedge CLK);
    if (watch_pulses && meas_complete_o)
      pulse_q.push_back(pins_now());
  endtask

  task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
    if (act !== exp) begin
      $display("error %s: expected %08h, actual %08h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_pins(input string name, input pins_t exp, input pins_t act);
    if (act !== exp) begin
      $display("error %s: expected %05h, actual %05h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [COUNT_W-1:0] exp,
                             input logic [COUNT_W-1:0] act);
    if (act !== exp) begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      value_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // command port, stall = cycles of rsp_ready_i low

  task automatic do_cmd(input logic wr, input reg_addr_t addr, input reg_word_t data,
                        input int stall, output reg_word_t rsp);
    int cyc;
    int i;
    rsp = '0;
    step_clk();
    cmd_valid_i = 1'b1;
    cmd_i.write = wr;
    cmd_i.addr  = addr;
    cmd_i.data  = data;
    rsp_ready_i = (stall == 0);
    cyc = 0;
    while (!cmd_ready_o && cyc < CMD_TIMEOUT) begin
      step_clk();
      cyc++;
    end
    if (!cmd_ready_o) begin
      $display("command port never became ready for addr %02h", addr);
      other_errors++;
      cmd_valid_i = 1'b0;
      return;
    end
    step_clk();                // transfer on the edge just passed
    cmd_valid_i = 1'b0;
    cyc = 0;
    while (!rsp_valid_o && cyc < CMD_TIMEOUT) begin
      step_clk();
      cyc++;
    end
    if (!rsp_valid_o) begin
      $display("no response for addr %02h", addr);
      other_errors++;
      rsp_ready_i = 1'b1;
      return;
    end
    for (i = 0; i < stall; i++) begin
      step_clk();
      if (!rsp_valid_o) begin
        $display("response dropped while rsp_ready_i was low, addr %02h", addr);
        other_errors++;
      end
      if (cmd_ready_o) begin
        $display("command port ready while a response was pending, addr %02h", addr);
        other_errors++;
      end
    end
    rsp = rsp_data_o;
    rsp_ready_i = 1'b1;        // taken on the next edge
  endtask

  ////////////////////////////////////////////////////////////
  // operations from the data file

  task automatic write_reg(input string name, input reg_addr_t addr, input reg_word_t value,
                           input reg_word_t expected);
    reg_word_t rsp;
    do_cmd(1'b1, addr, value, 0, rsp);
    check_word($sformatf("%s write echo", name), expected, rsp);
    case (addr)
      REG_SA_AZMUX_LO: sh_azmux_lo = value[AZMUX_W-1:0];
      REG_SA_AZMUX_HI: sh_azmux_hi = value[AZMUX_W-1:0];
      REG_SA_PC_HI:    sh_pc_hi    = value[PC_SW_W-1:0];
      default: ;
    endcase
  endtask

  task automatic read_reg(input string name, input reg_addr_t addr, input reg_word_t flags,
                          input reg_word_t expected);
    reg_word_t rsp;
    int        stall;
    hw_flags_i = flags[HW_FLAGS_W-1:0];
    lcg_state  = lcg_next(lcg_state);
    stall      = int'(lcg_state[17:16]);    // 0..3 cycles back-pressure
    do_cmd(1'b0, addr, '0, stall, rsp);
    check_word(name, expected, rsp);
  endtask

  task automatic mode_pins_test(input string name, input reg_word_t mode,
                                input reg_word_t expected);
    reg_word_t rsp;
    do_cmd(1'b1, REG_MODE, mode, 0, rsp);
    step_clk();
    step_clk();                             // pins lag the mode by one register
    check_pins(name, pins_t'(expected[$bits(pins_t)-1:0]), pins_now());
  endtask

  task automatic az_sequence_test(input string name, input reg_word_t mode, input int pulses,
                                  input reg_word_t exp_count);
    reg_word_t rsp;
    pins_t     exp;
    int        cyc;
    int        quiet;
    int        last;
    int        n;
    int        i;
    do_cmd(1'b1, REG_MODE, mode, 0, rsp);
    step_clk();
    step_clk();
    pulse_q.delete();
    watch_pulses = 1'b1;
    do_cmd(1'b1, REG_SA_ARM, 32'd1, 0, rsp);
    cyc = 0;
    while (pulse_q.size() < pulses && cyc < AZ_TIMEOUT) begin
      step_clk();
      cyc++;
    end
    if (pulse_q.size() < pulses) begin
      $display("%s: too few meas_complete pulses before disarm", name);
      other_errors++;
    end
    do_cmd(1'b1, REG_SA_ARM, 32'd0, 0, rsp);
    // current pair still finishes
    cyc   = 0;
    quiet = 0;
    last  = pulse_q.size();
    while (quiet < QUIET_CYC && cyc < AZ_TIMEOUT) begin
      step_clk();
      cyc++;
      if (pulse_q.size() != last) begin
        quiet = 0;
        last  = pulse_q.size();
      end else begin
        quiet++;
      end
    end
    if (quiet < QUIET_CYC) begin
      $display("%s: meas_complete kept pulsing after disarm", name);
      other_errors++;
    end
    watch_pulses = 1'b0;
    n = pulse_q.size();
    if (n % 2 != 0) begin
      $display("%s: odd number of conversions, %0d", name, n);
      other_errors++;
    end
    for (i = 0; i < n; i++) begin
      exp               = '0;
      exp.meas_complete = 1'b1;
      if (i % 2 == 0) begin                 // hi first
        exp.azmux   = sh_azmux_hi;
        exp.pc_sw   = sh_pc_hi;
        exp.monitor = {5'b0, 1'b0, SA_SAMPLE_HI};   // adc idle again at done
        exp.leds[0] = 1'b1;
      end else begin
        exp.azmux   = sh_azmux_lo;
        exp.monitor = {5'b0, 1'b0, SA_SAMPLE_LO};
      end
      check_pins($sformatf("%s pulse %0d", name, i), exp, pulse_q[i]);
    end
    do_cmd(1'b0, REG_SA_COUNT, '0, 2, rsp);
    check_count($sformatf("%s pair count", name), exp_count[COUNT_W-1:0], rsp[COUNT_W-1:0]);
    check_count($sformatf("%s pulses halved", name), exp_count[COUNT_W-1:0],
                COUNT_W'(n / 2));
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    reg_word_t op;
    reg_word_t addr;
    reg_word_t value;
    reg_word_t expected;
    string     name;
    int        idx;
    logic      done;
    CLK          = 1'b0;
    reset_i      = 1'b1;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    rsp_ready_i  = 1'b1;
    hw_flags_i   = '0;
    watch_pulses = 1'b0;
    value_errors = 0;
    other_errors = 0;
    lcg_state    = 32'd41;
    sh_azmux_lo  = '0;
    sh_azmux_hi  = '0;
    sh_pc_hi     = '0;
    $readmemh("tb/dmm_testdata.txt", testdata);
    if ($isunknown(testdata[0])) begin
      $display("data file tb/dmm_testdata.txt could not be read");
      other_errors++;
    end
    repeat (5) step_clk();
    reset_i = 1'b0;
    step_clk();
    check_pins("pins after reset", '0, pins_now());
    check_word("response data after reset", '0, rsp_data_o);
    if (!cmd_ready_o || rsp_valid_o) begin
      $display("command handshake not idle after reset");
      other_errors++;
    end

    idx  = 0;
    done = $isunknown(testdata[0]);
    while (!done && idx < MAX_OPS) begin
      op       = testdata[4*idx];
      addr     = testdata[4*idx+1];
      value    = testdata[4*idx+2];
      expected = testdata[4*idx+3];
      name     = $sformatf("op %0d addr %02h", idx, addr[7:0]);
      case (op)
        32'h0: write_reg(name, reg_addr_t'(addr[7:0]), value, expected);
        32'h1: read_reg(name, reg_addr_t'(addr[7:0]), value, expected);
        32'h2: mode_pins_test(name, addr, expected);
        32'h3: az_sequence_test(name, addr, int'(value), expected);
        32'hF: done = 1'b1;
        default: begin
          $display("unknown operation %0h in data file at op %0d", op, idx);
          other_errors++;
          done = 1'b1;
        end
      endcase
      idx++;
    end

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/dmm_top.sv ====
`default_nettype none

module dmm_top
  import dmm_pkg::*;
#(
  parameter int COUNT_W = 16
) (
  input  logic                  CLK,
  input  logic                  reset_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  reg_cmd_t              cmd_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output reg_word_t             rsp_data_o,
  input  logic [HW_FLAGS_W-1:0] hw_flags_i,
  output logic [LEDS_W-1:0]     leds_o,
  output logic [MONITOR_W-1:0]  monitor_o,
  output logic [AZMUX_W-1:0]    azmux_o,
  output logic [PC_SW_W-1:0]    pc_sw_o,
  output logic                  meas_complete_o
);

  mode_t              mode;
  reg_word_t          direct;
  logic               sa_arm;
  sa_params_t         sa_params;
  logic [COUNT_W-1:0] sa_count;
  sa_state_t          sa_state;
  logic [AZMUX_W-1:0] sa_azmux;
  logic [PC_SW_W-1:0] sa_pc_sw;
  logic               adc_start;
  logic               adc_ready;
  logic               adc_done;
  logic               adc_busy;
  pins_t              az_pins;
  pins_t              pins;

  ////////////////////////////////////////////////////////////
  // input side

  reg_bank #(
    .COUNT_W(COUNT_W)
  ) i_reg_bank (
    .CLK        (CLK),
    .reset_i    (reset_i),
    .cmd_valid_i(cmd_valid_i),
    .cmd_ready_o(cmd_ready_o),
    .cmd_i      (cmd_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_data_o (rsp_data_o),
    .hw_flags_i (hw_flags_i),
    .sa_count_i (sa_count),
    .mode_o     (mode),
    .direct_o   (direct),
    .sa_arm_o   (sa_arm),
    .sa_params_o(sa_params)
  );

  ////////////////////////////////////////////////////////////
  // acquisition and mock converter

  sample_acq_az #(
    .COUNT_W(COUNT_W)
  ) i_sample_acq_az (
    .CLK        (CLK),
    .reset_i    (reset_i),
    .arm_i      (sa_arm),
    .params_i   (sa_params),
    .adc_start_o(adc_start),
    .adc_ready_i(adc_ready),
    .adc_done_i (adc_done),
    .azmux_o    (sa_azmux),
    .pc_sw_o    (sa_pc_sw),
    .state_o    (sa_state),
    .count_o    (sa_count)
  );

  adc_mock i_adc_mock (
    .CLK       (CLK),
    .reset_i   (reset_i),
    .start_i   (adc_start),
    .ready_o   (adc_ready),
    .aperture_i(sa_params.aperture),
    .done_o    (adc_done),
    .busy_o    (adc_busy)
  );

  // az test bundle
  assign az_pins.meas_complete = adc_done;
  assign az_pins.azmux         = sa_azmux;
  assign az_pins.pc_sw         = sa_pc_sw;
  assign az_pins.monitor       = {5'b0, adc_busy, sa_state};   // state in [1:0], busy [2]
  assign az_pins.leds          = {3'b0, sa_state == SA_SAMPLE_HI};  // led0 during hi

  ////////////////////////////////////////////////////////////
  // output side

  output_mux i_output_mux (
    .CLK     (CLK),
    .reset_i (reset_i),
    .mode_i  (mode),
    .direct_i(direct),
    .az_i    (az_pins),
    .pins_o  (pins)
  );

  assign meas_complete_o = pins.meas_complete;
  assign azmux_o         = pins.azmux;
  assign pc_sw_o         = pins.pc_sw;
  assign monitor_o       = pins.monitor;
  assign leds_o          = pins.leds;

endmodule

`default_nettype wire

// ==== hw/output_mux.sv ====
`default_nettype none

module output_mux
  import dmm_pkg::*;
(
  input  logic      CLK,
  input  logic      reset_i,
  input  mode_t     mode_i,
  input  reg_word_t direct_i,
  input  pins_t     az_i,
  output pins_t     pins_o
);

  pins_t pins_sel;
  pins_t pins_r;

  ////////////////////////////////////////////////////////////
  // alternate function select

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  pins_sel = pins_t'(direct_i[$bits(pins_t)-1:0]);  // low bits of direct
      MODE_LO:      pins_sel = '0;
      MODE_HI:      pins_sel = '1;        // everything hi
      MODE_AZ_TEST: pins_sel = az_i;
      default:      pins_sel = '0;        // unused modes, all low
    endcase
  end

  // one cycle lag to the pins
  always_ff @(posedge CLK) begin
    if (reset_i)
      pins_r <= '0;
    else
      pins_r <= pins_sel;
  end

  assign pins_o = pins_r;

endmodule

`default_nettype wire

// ==== hw/sample_acq_az.sv ====
`default_nettype none

module sample_acq_az
  import dmm_pkg::*;
#(
  parameter int COUNT_W = 16
) (
  input  logic               CLK,
  input  logic               reset_i,
  input  logic               arm_i,
  input  sa_params_t         params_i,
  output logic               adc_start_o,
  input  logic               adc_ready_i,
  input  logic               adc_done_i,
  output logic [AZMUX_W-1:0] azmux_o,
  output logic [PC_SW_W-1:0] pc_sw_o,
  output sa_state_t          state_o,
  output logic [COUNT_W-1:0] count_o
);

  sa_state_t              state_r;
  logic [PRECHARGE_W-1:0] pc_cnt;      // precharge countdown
  logic                   start_r;     // adc request pending
  logic [COUNT_W-1:0]     count_r;     // completed hi/lo pairs

  ////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      state_r <= SA_IDLE;
      pc_cnt  <= '0;
      start_r <= 1'b0;
      count_r <= '0;
    end else begin
      // drop request once the adc takes it
      if (start_r && adc_ready_i)
        start_r <= 1'b0;

      case (state_r)
        SA_IDLE: begin
          if (arm_i) begin
            state_r <= SA_PRECHARGE;
            pc_cnt  <= params_i.precharge;
          end
        end

        SA_PRECHARGE: begin
          // hold precharge-count cycles, min one
          if (pc_cnt <= 1) begin
            state_r <= SA_SAMPLE_HI;
            start_r <= 1'b1;              // first of the pair
          end else begin
            pc_cnt <= pc_cnt - 1'b1;
          end
        end

        SA_SAMPLE_HI: begin
          if (adc_done_i) begin
            state_r <= SA_SAMPLE_LO;
            start_r <= 1'b1;              // lo conversion
          end
        end

        SA_SAMPLE_LO: begin
          if (adc_done_i) begin
            count_r <= count_r + 1'b1;    // pair complete
            if (arm_i) begin
              state_r <= SA_PRECHARGE;
              pc_cnt  <= params_i.precharge;
            end else begin
              state_r <= SA_IDLE;         // disarm honoured only here
            end
          end
        end

        default: state_r <= SA_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // switch outputs, decoded from state

  always_comb begin
    azmux_o = '0;
    pc_sw_o = '0;
    case (state_r)
      SA_PRECHARGE: azmux_o = params_i.azmux_lo;   // park on lo during precharge
      SA_SAMPLE_HI: begin
        azmux_o = params_i.azmux_hi;
        pc_sw_o = params_i.pc_hi;                  // switches only in hi
      end
      SA_SAMPLE_LO: azmux_o = params_i.azmux_lo;
      default: ;
    endcase
  end

  assign adc_start_o = start_r;
  assign state_o     = state_r;
  assign count_o     = count_r;

endmodule

`default_nettype wire

// ==== hw/adc_mock.sv ====
`default_nettype none

module adc_mock
  import dmm_pkg::*;
(
  input  logic      CLK,
  input  logic      reset_i,
  input  logic      start_i,      // request, held until ready
  output logic      ready_o,
  input  reg_word_t aperture_i,   // clk count per conversion
  output logic      done_o,       // one cycle pulse
  output logic      busy_o
);

  logic      busy_r;
  logic      done_r;
  reg_word_t count_r;

  assign ready_o = !busy_r;     // accept only while idle

  // stand-in for the modulator. just burn aperture clocks
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      busy_r  <= 1'b0;
      done_r  <= 1'b0;
      count_r <= '0;
    end else begin
      done_r <= 1'b0;
      if (!busy_r) begin
        if (start_i) begin
          busy_r  <= 1'b1;
          count_r <= aperture_i;      // load on accept
        end
      end else if (count_r == '0) begin
        busy_r <= 1'b0;
        done_r <= 1'b1;               // aperture+1 after accept
      end else begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  assign done_o = done_r;
  assign busy_o = busy_r;

endmodule

`default_nettype wire

// ==== hw/reg_bank.sv ====
`default_nettype none

module reg_bank
  import dmm_pkg::*;
#(
  parameter int COUNT_W = 16
) (
  input  logic                  CLK,
  input  logic                  reset_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  reg_cmd_t              cmd_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output reg_word_t             rsp_data_o,
  input  logic [HW_FLAGS_W-1:0] hw_flags_i,
  input  logic [COUNT_W-1:0]    sa_count_i,
  output mode_t                 mode_o,
  output reg_word_t             direct_o,
  output logic                  sa_arm_o,
  output sa_params_t            sa_params_o
);

  mode_t      mode_r;
  reg_word_t  direct_r;
  logic       arm_r;           // sequencer run
  sa_params_t params_r;
  logic       rsp_valid_r;
  reg_word_t  rsp_data_r;
  reg_word_t  rd_data;
  logic       cmd_fire;

  assign cmd_ready_o = !rsp_valid_r;              // one outstanding response
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  ////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    case (cmd_i.addr)
      REG_MODE:         rd_data = reg_word_t'(mode_r);
      REG_DIRECT:       rd_data = direct_r;
      REG_STATUS:       rd_data = reg_word_t'({hw_flags_i, STATUS_MAGIC});  // flags above magic
      REG_SA_ARM:       rd_data = reg_word_t'(arm_r);
      REG_SA_PRECHARGE: rd_data = reg_word_t'(params_r.precharge);
      REG_SA_AZMUX_LO:  rd_data = reg_word_t'(params_r.azmux_lo);
      REG_SA_AZMUX_HI:  rd_data = reg_word_t'(params_r.azmux_hi);
      REG_SA_PC_HI:     rd_data = reg_word_t'(params_r.pc_hi);
      REG_ADC_APERTURE: rd_data = params_r.aperture;
      REG_SA_COUNT:     rd_data = reg_word_t'(sa_count_i);    // zero extend
      default:          rd_data = '0;                          // unknown addr
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register writes and response handshake

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      mode_r      <= MODE_DIRECT;
      direct_r    <= '0;
      arm_r       <= 1'b0;
      params_r    <= '0;
      rsp_valid_r <= 1'b0;
    end else begin
      if (cmd_fire && cmd_i.write) begin
        case (cmd_i.addr)
          REG_MODE:         mode_r            <= mode_t'(cmd_i.data[2:0]);
          REG_DIRECT:       direct_r          <= cmd_i.data;
          REG_SA_ARM:       arm_r             <= cmd_i.data[0];
          REG_SA_PRECHARGE: params_r.precharge <= cmd_i.data[PRECHARGE_W-1:0];
          REG_SA_AZMUX_LO:  params_r.azmux_lo <= cmd_i.data[AZMUX_W-1:0];
          REG_SA_AZMUX_HI:  params_r.azmux_hi <= cmd_i.data[AZMUX_W-1:0];
          REG_SA_PC_HI:     params_r.pc_hi    <= cmd_i.data[PC_SW_W-1:0];
          REG_ADC_APERTURE: params_r.aperture <= cmd_i.data;
          default: ;                          // status, count, unknown dropped
        endcase
      end
      if (cmd_fire)
        rsp_valid_r <= 1'b1;
      else if (rsp_ready_i)
        rsp_valid_r <= 1'b0;                  // response taken
    end
  end

  // response payload, write echoes data
  always_ff @(posedge CLK) begin
    if (reset_i)
      rsp_data_r <= '0;
    else if (cmd_fire)
      rsp_data_r <= cmd_i.write ? cmd_i.data : rd_data;
  end

  assign rsp_valid_o = rsp_valid_r;
  assign rsp_data_o  = rsp_data_r;
  assign mode_o      = mode_r;
  assign direct_o    = direct_r;
  assign sa_arm_o    = arm_r;
  assign sa_params_o = params_r;

endmodule

`default_nettype wire

// ==== hw/dmm_pkg.sv ====
`default_nettype none

package dmm_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  localparam int HW_FLAGS_W   = 4;       // board flag inputs
  localparam int PRECHARGE_W  = 24;      // precharge clk count
  localparam int AZMUX_W      = 4;       // az mux select
  localparam int PC_SW_W      = 2;       // precharge switches
  localparam int MONITOR_W    = 8;
  localparam int LEDS_W       = 4;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;   // low byte of status, fixed

  typedef logic [31:0] reg_word_t;

  ////////////////////////////////////////////////////////////
  // enums

  // register map
  typedef enum logic [7:0] {
    REG_MODE          = 8'h00,
    REG_DIRECT        = 8'h01,
    REG_STATUS        = 8'h02,   // read only
    REG_SA_ARM        = 8'h03,
    REG_SA_PRECHARGE  = 8'h04,
    REG_SA_AZMUX_LO   = 8'h05,
    REG_SA_AZMUX_HI   = 8'h06,
    REG_SA_PC_HI      = 8'h07,
    REG_ADC_APERTURE  = 8'h08,
    REG_SA_COUNT      = 8'h09    // read only, pair count
  } reg_addr_t;

  // output mode / alternate function
  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,
    MODE_LO       = 3'd1,
    MODE_HI       = 3'd2,
    MODE_AZ_TEST  = 3'd5       // az sequencer with mock adc
  } mode_t;

  typedef enum logic [1:0] {
    SA_IDLE,
    SA_PRECHARGE,
    SA_SAMPLE_HI,
    SA_SAMPLE_LO
  } sa_state_t;

  ////////////////////////////////////////////////////////////
  // bundles

  typedef struct packed {
    logic      write;          // 1 write, 0 read
    reg_addr_t addr;
    reg_word_t data;           // ignored on read
  } reg_cmd_t;

  typedef struct packed {
    logic [PRECHARGE_W-1:0] precharge;
    logic [AZMUX_W-1:0]     azmux_lo;
    logic [AZMUX_W-1:0]     azmux_hi;
    logic [PC_SW_W-1:0]     pc_hi;
    reg_word_t              aperture;   // adc clk count
  } sa_params_t;

  // board pins, msb first
  typedef struct packed {
    logic                 meas_complete;
    logic [AZMUX_W-1:0]   azmux;
    logic [PC_SW_W-1:0]   pc_sw;
    logic [MONITOR_W-1:0] monitor;
    logic [LEDS_W-1:0]    leds;
  } pins_t;

endpackage

`default_nettype wire
